// ==== rtl/ControlUnitPkg.sv ====
`default_nettype none

package ControlUnitPkg;

    // Enough for the longest fetch wait
    localparam int StepWidth = 3;

    typedef enum logic [5:0] {
        OpRType = 6'b000000,
        OpAddi  = 6'b001000,
        OpAddiu = 6'b001001
    } opcode_e;

    typedef enum logic [5:0] {
        FunctAdd = 6'b100000,
        FunctSub = 6'b100010,
        FunctAnd = 6'b100100
    } funct_e;

    typedef enum logic [2:0] {
        ClassAdd     = 3'd0,
        ClassSub     = 3'd1,
        ClassAnd     = 3'd2,
        ClassAddi    = 3'd3,
        ClassAddiu   = 3'd4,
        ClassIllegal = 3'd5
    } instrClass_e;

    typedef enum logic [2:0] {
        PhaseReset      = 3'd0,
        PhaseFetch      = 3'd1,
        PhaseFetchLatch = 3'd2,
        PhaseDecode     = 3'd3,
        PhaseExecute    = 3'd4,
        PhaseWriteback  = 3'd5,
        PhaseTrap       = 3'd6,
        PhaseTrapJump   = 3'd7
    } phase_e;

    typedef enum logic [1:0] {
        AluAdd = 2'd0,
        AluSub = 2'd1,
        AluAnd = 2'd2
    } aluOp_e;

    typedef enum logic {
        SrcPc   = 1'b0,
        SrcRegA = 1'b1
    } aluSrcA_e;

    typedef enum logic [1:0] {
        SrcRegB      = 2'd0,
        SrcFour      = 2'd1,
        SrcImmediate = 2'd2
    } aluSrcB_e;

    typedef enum logic {
        PcAluResult       = 1'b0,
        PcExceptionVector = 1'b1
    } pcSource_e;

    typedef enum logic {
        DstRt = 1'b0,
        DstRd = 1'b1
    } regDst_e;

    typedef enum logic [1:0] {
        CauseNone     = 2'd0,
        CauseOverflow = 2'd1,
        CauseIllegal  = 2'd2
    } cause_e;

    // One word per cycle towards the datapath
    typedef struct packed {
        logic      memRead;
        logic      irWrite;
        logic      pcWrite;
        pcSource_e pcSource;
        aluSrcA_e  aluSrcA;
        aluSrcB_e  aluSrcB;
        aluOp_e    aluOp;
        logic      aluOutWrite;
        logic      writeA;
        logic      writeB;
        logic      regWrite;
        regDst_e   regDst;
        logic      epcWrite;
        cause_e    cause;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== rtl/InstructionDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module InstructionDecoder (
    input  wire logic [5:0]               opCode,
    input  wire logic [5:0]               funct,
    output ControlUnitPkg::instrClass_e   instrClass
);

    ControlUnitPkg::instrClass_e rTypeClass;

    // R-type group, selected by funct
    always_comb begin
        case (funct)
            ControlUnitPkg::FunctAdd: begin
                rTypeClass = ControlUnitPkg::ClassAdd;
            end
            ControlUnitPkg::FunctSub: begin
                rTypeClass = ControlUnitPkg::ClassSub;
            end
            ControlUnitPkg::FunctAnd: begin
                rTypeClass = ControlUnitPkg::ClassAnd;
            end
            default: begin
                rTypeClass = ControlUnitPkg::ClassIllegal;
            end
        endcase
    end

    // Primary opcode picks the format
    always_comb begin
        case (opCode)
            ControlUnitPkg::OpRType: begin
                instrClass = rTypeClass;
            end
            ControlUnitPkg::OpAddi: begin
                instrClass = ControlUnitPkg::ClassAddi;
            end
            ControlUnitPkg::OpAddiu: begin
                instrClass = ControlUnitPkg::ClassAddiu;
            end
            default: begin
                // anything else is reported as undefined
                instrClass = ControlUnitPkg::ClassIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/CycleSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module CycleSequencer #(
    parameter int MemWaitCycles = 3
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        overflow,
    input  wire ControlUnitPkg::instrClass_e instrClass,
    output ControlUnitPkg::phase_e           phase,
    output logic                             resetOut
);

    localparam int FetchLast = MemWaitCycles - 1;
    localparam int DecodeLast = 1;

    localparam logic [ControlUnitPkg::StepWidth-1:0] FetchLastStep =
        FetchLast[ControlUnitPkg::StepWidth-1:0];
    localparam logic [ControlUnitPkg::StepWidth-1:0] DecodeLastStep =
        DecodeLast[ControlUnitPkg::StepWidth-1:0];

    ControlUnitPkg::phase_e nextPhase;
    logic [ControlUnitPkg::StepWidth-1:0] step;
    logic [ControlUnitPkg::StepWidth-1:0] nextStep;
    logic isIllegal;
    logic overflowTrap;

    assign isIllegal = (instrClass == ControlUnitPkg::ClassIllegal);

    // Only the signed adds and SUB trap on overflow
    always_comb begin
        case (instrClass)
            ControlUnitPkg::ClassAdd,
            ControlUnitPkg::ClassSub,
            ControlUnitPkg::ClassAddi: begin
                overflowTrap = overflow;
            end
            default: begin
                overflowTrap = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextPhase = phase;
        nextStep = '0;
        case (phase)
            ControlUnitPkg::PhaseReset: begin
                nextPhase = ControlUnitPkg::PhaseFetch;
            end
            ControlUnitPkg::PhaseFetch: begin
                // Wait out the memory latency
                if (step == FetchLastStep) begin
                    nextPhase = ControlUnitPkg::PhaseFetchLatch;
                end else begin
                    nextStep = step + 1'b1;
                end
            end
            ControlUnitPkg::PhaseFetchLatch: begin
                nextPhase = ControlUnitPkg::PhaseDecode;
            end
            ControlUnitPkg::PhaseDecode: begin
                // IR holds the new word only in the second cycle
                if (step == DecodeLastStep) begin
                    if (isIllegal) begin
                        nextPhase = ControlUnitPkg::PhaseTrap;
                    end else begin
                        nextPhase = ControlUnitPkg::PhaseExecute;
                    end
                end else begin
                    nextStep = step + 1'b1;
                end
            end
            ControlUnitPkg::PhaseExecute: begin
                if (overflowTrap) begin
                    nextPhase = ControlUnitPkg::PhaseTrap;
                end else begin
                    nextPhase = ControlUnitPkg::PhaseWriteback;
                end
            end
            ControlUnitPkg::PhaseWriteback: begin
                nextPhase = ControlUnitPkg::PhaseFetch;
            end
            ControlUnitPkg::PhaseTrap: begin
                nextPhase = ControlUnitPkg::PhaseTrapJump;
            end
            ControlUnitPkg::PhaseTrapJump: begin
                nextPhase = ControlUnitPkg::PhaseFetch;
            end
            default: begin
                nextPhase = ControlUnitPkg::PhaseReset;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ControlUnitPkg::PhaseReset;
            step <= '0;
        end else begin
            phase <= nextPhase;
            step <= nextStep;
        end
    end

    // Held high until the first fetch
    assign resetOut = (phase == ControlUnitPkg::PhaseReset);

endmodule

`default_nettype wire

// ==== rtl/ControlWordGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module ControlWordGen (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire ControlUnitPkg::phase_e      phase,
    input  wire ControlUnitPkg::instrClass_e instrClass,
    output ControlUnitPkg::ctrlWord_t        ctrl
);

    ControlUnitPkg::ctrlWord_t nextCtrl;
    ControlUnitPkg::aluOp_e classAluOp;
    logic isRType;

    always_comb begin
        isRType = 1'b0;
        classAluOp = ControlUnitPkg::AluAdd;
        case (instrClass)
            ControlUnitPkg::ClassAdd: begin
                isRType = 1'b1;
            end
            ControlUnitPkg::ClassSub: begin
                isRType = 1'b1;
                classAluOp = ControlUnitPkg::AluSub;
            end
            ControlUnitPkg::ClassAnd: begin
                isRType = 1'b1;
                classAluOp = ControlUnitPkg::AluAnd;
            end
            default: begin
                // immediates add, illegal never reaches Execute
                classAluOp = ControlUnitPkg::AluAdd;
            end
        endcase
    end

    always_comb begin
        nextCtrl = '0;
        case (phase)
            ControlUnitPkg::PhaseFetch,
            ControlUnitPkg::PhaseFetchLatch: begin
                // PC + 4 computed during the whole fetch
                nextCtrl.aluSrcA = ControlUnitPkg::SrcPc;
                nextCtrl.aluSrcB = ControlUnitPkg::SrcFour;
                nextCtrl.aluOp = ControlUnitPkg::AluAdd;
                nextCtrl.pcSource = ControlUnitPkg::PcAluResult;
                nextCtrl.memRead = (phase == ControlUnitPkg::PhaseFetch);
                nextCtrl.irWrite = (phase == ControlUnitPkg::PhaseFetchLatch);
                nextCtrl.pcWrite = (phase == ControlUnitPkg::PhaseFetchLatch);
            end
            ControlUnitPkg::PhaseDecode: begin
                nextCtrl.writeA = 1'b1;
                nextCtrl.writeB = 1'b1;
            end
            ControlUnitPkg::PhaseExecute: begin
                nextCtrl.aluSrcA = ControlUnitPkg::SrcRegA;
                if (isRType) begin
                    nextCtrl.aluSrcB = ControlUnitPkg::SrcRegB;
                end else begin
                    nextCtrl.aluSrcB = ControlUnitPkg::SrcImmediate;
                end
                nextCtrl.aluOp = classAluOp;
                nextCtrl.aluOutWrite = 1'b1;
            end
            ControlUnitPkg::PhaseWriteback: begin
                nextCtrl.regWrite = 1'b1;
                if (isRType) begin
                    nextCtrl.regDst = ControlUnitPkg::DstRd;
                end else begin
                    nextCtrl.regDst = ControlUnitPkg::DstRt;
                end
            end
            ControlUnitPkg::PhaseTrap: begin
                nextCtrl.epcWrite = 1'b1;
                if (instrClass == ControlUnitPkg::ClassIllegal) begin
                    nextCtrl.cause = ControlUnitPkg::CauseIllegal;
                end else begin
                    nextCtrl.cause = ControlUnitPkg::CauseOverflow;
                end
            end
            ControlUnitPkg::PhaseTrapJump: begin
                nextCtrl.pcWrite = 1'b1;
                nextCtrl.pcSource = ControlUnitPkg::PcExceptionVector;
            end
            default: begin
                nextCtrl = '0;
            end
        endcase
    end

    // Word lags its phase by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            ctrl <= nextCtrl;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ControlUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module ControlUnit #(
    // Fetch wait in cycles, 1 to 7
    parameter int MemWaitCycles = 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 overflow,
    input  wire logic [5:0]           opCode,
    input  wire logic [5:0]           funct,
    output ControlUnitPkg::ctrlWord_t ctrl,
    output logic                      resetOut
);

    ControlUnitPkg::instrClass_e instrClass;
    ControlUnitPkg::phase_e phase;

    InstructionDecoder decoder (
        .opCode     (opCode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    CycleSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .overflow   (overflow),
        .instrClass (instrClass),
        .phase      (phase),
        .resetOut   (resetOut)
    );

    // Registered word straight to the datapath
    ControlWordGen wordGen (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .instrClass (instrClass),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// ==== tests/ControlUnitTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ControlUnitTb;

    localparam int MemWaitCycles = 3;
    localparam int ClockPeriod = 4;
    localparam int CyclesPerEntry = 12;
    localparam int WindowLimit = 20;
    localparam int DecodeCycles = 2;
    localparam string StimulusFile = "tests/ControlUnit_stimulus.txt";

    // One instruction with its expected results
    typedef struct packed {
        logic [5:0] opCode;
        logic [5:0] funct;
        logic       overflow;
        logic [1:0] aluOp;
        logic       regDst;
        logic [1:0] cause;
        logic [3:0] interval;
    } testVec_t;

    logic clk;
    logic reset;
    logic overflow;
    logic [5:0] opCode;
    logic [5:0] funct;
    ControlUnitPkg::ctrlWord_t ctrl;
    logic resetOut;

    testVec_t vectors[$];
    string names[$];
    int seed;
    int mismatchCount;
    int failureCount;
    int memReadRun;
    bit vectorsReady;

    ControlUnit #(
        .MemWaitCycles (MemWaitCycles)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .overflow (overflow),
        .opCode   (opCode),
        .funct    (funct),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    task automatic compareValue(input string name, input string field, input int expected,
                                input int actual);
        assert (expected == actual) else begin
            $display("Mismatch %s %s: expected %0d, actual %0d", name, field, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic requireTrue(input bit condition, input string message);
        assert (condition) else begin
            $display("Error: %s", message);
            failureCount++;
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ADDIU never traps so only the fetch length sets the interval
    function automatic testVec_t makeFiller(input logic [31:0] randomWord);
        testVec_t filler;
        filler.opCode = ControlUnitPkg::OpAddiu;
        filler.funct = randomWord[7:2];
        filler.overflow = randomWord[8];
        filler.aluOp = ControlUnitPkg::AluAdd;
        filler.regDst = ControlUnitPkg::DstRt;
        filler.cause = ControlUnitPkg::CauseNone;
        filler.interval = 4'(MemWaitCycles + 5);
        return filler;
    endfunction

    task automatic readVectors();
        int fd;
        int count;
        string line;
        string name;
        logic [5:0] op;
        logic [5:0] fn;
        logic ov;
        logic [1:0] aluOp;
        logic dst;
        logic [1:0] cause;
        logic [3:0] interval;
        logic [31:0] randomWord;
        fd = $fopen(StimulusFile, "r");
        if (fd == 0) begin
            requireTrue(1'b0, "could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%s %h %h %h %h %h %h %h", name, op, fn, ov, aluOp, dst,
                                cause, interval);
                if (count == 8 && line.getc(0) != "#") begin
                    vectors.push_back('{op, fn, ov, aluOp, dst, cause, interval});
                    names.push_back(name);
                    randomWord = $random(seed);
                    if (randomWord[0]) begin
                        vectors.push_back(makeFiller(randomWord));
                        names.push_back($sformatf("addiu_fill_%0d", vectors.size()));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic verifyResetState();
        compareValue("reset", "ctrl word", 0, int'(ctrl));
        requireTrue(resetOut, "resetOut is low while the unit is in reset");
    endtask

    // Called on the sample that shows irWrite
    task automatic inspectFetchLatch(input string name);
        compareValue(name, "memRead run", MemWaitCycles, memReadRun);
        requireTrue(ctrl.pcWrite && ctrl.pcSource == ControlUnitPkg::PcAluResult &&
                    ctrl.aluSrcA == ControlUnitPkg::SrcPc &&
                    ctrl.aluSrcB == ControlUnitPkg::SrcFour &&
                    ctrl.aluOp == ControlUnitPkg::AluAdd,
                    $sformatf("%s: PC + 4 is not written together with irWrite", name));
        memReadRun = 0;
    endtask

    task automatic waitFirstFetch();
        int cycles;
        bit seenIrWrite;
        cycles = 0;
        seenIrWrite = 1'b0;
        memReadRun = 0;
        while (!seenIrWrite && cycles < WindowLimit) begin
            @(negedge clk);
            cycles++;
            if (ctrl.memRead || ctrl.irWrite) begin
                requireTrue(!resetOut, "resetOut still high once fetching has started");
            end
            if (ctrl.irWrite) begin
                seenIrWrite = 1'b1;
                inspectFetchLatch("startup");
            end else if (ctrl.memRead) begin
                memReadRun++;
            end else begin
                compareValue("startup", "ctrl word", 0, int'(ctrl));
            end
        end
        requireTrue(seenIrWrite, "no instruction fetch completed after reset");
    endtask

    task automatic runInstruction(input string name, input testVec_t vec);
        int cycles;
        int aluCycle;
        int regCycle;
        int epcCycle;
        int jumpCycle;
        int aluCount;
        int regCount;
        int epcCount;
        int jumpCount;
        int decodeCount;
        bit trapExpected;
        bit seenIrWrite;
        ControlUnitPkg::aluSrcB_e expSrcB;
        cycles = 0;
        aluCycle = 0;
        regCycle = 0;
        epcCycle = 0;
        jumpCycle = 0;
        aluCount = 0;
        regCount = 0;
        epcCount = 0;
        jumpCount = 0;
        decodeCount = 0;
        seenIrWrite = 1'b0;
        trapExpected = (vec.cause != ControlUnitPkg::CauseNone);
        expSrcB = (vec.opCode == ControlUnitPkg::OpRType) ? ControlUnitPkg::SrcRegB :
            ControlUnitPkg::SrcImmediate;

        // New instruction word lands in the second decode cycle
        @(posedge clk);
        opCode <= vec.opCode;
        funct <= vec.funct;
        overflow <= vec.overflow;
        while (!seenIrWrite && cycles < WindowLimit) begin
            @(negedge clk);
            cycles++;
            requireTrue(!resetOut, $sformatf("%s: resetOut went high again", name));
            if (ctrl.writeA && ctrl.writeB) begin
                decodeCount++;
            end
            if (ctrl.regWrite) begin
                regCount++;
                regCycle = cycles;
                compareValue(name, "regDst", int'(vec.regDst), int'(ctrl.regDst));
            end
            if (ctrl.epcWrite) begin
                epcCount++;
                epcCycle = cycles;
                compareValue(name, "cause", int'(vec.cause), int'(ctrl.cause));
            end
            if (ctrl.pcWrite && ctrl.pcSource == ControlUnitPkg::PcExceptionVector) begin
                jumpCount++;
                jumpCycle = cycles;
            end
            if (ctrl.irWrite) begin
                seenIrWrite = 1'b1;
                inspectFetchLatch(name);
            end else if (ctrl.memRead) begin
                memReadRun++;
            end else begin
                memReadRun = 0;
            end
            // Overflow drops once the Execute word is out
            if (ctrl.aluOutWrite) begin
                aluCount++;
                aluCycle = cycles;
                compareValue(name, "aluOp", int'(vec.aluOp), int'(ctrl.aluOp));
                compareValue(name, "aluSrcA", int'(ControlUnitPkg::SrcRegA),
                             int'(ctrl.aluSrcA));
                compareValue(name, "aluSrcB", int'(expSrcB), int'(ctrl.aluSrcB));
                @(posedge clk);
                overflow <= 1'b0;
            end
        end

        requireTrue(seenIrWrite, $sformatf("%s: no next fetch within %0d cycles", name, cycles));
        compareValue(name, "irWrite interval", int'(vec.interval), cycles);
        compareValue(name, "operand latch count", DecodeCycles, decodeCount);
        compareValue(name, "aluOutWrite count",
                     (vec.cause == ControlUnitPkg::CauseIllegal) ? 0 : 1, aluCount);
        compareValue(name, "regWrite count", trapExpected ? 0 : 1, regCount);
        compareValue(name, "epcWrite count", trapExpected ? 1 : 0, epcCount);
        compareValue(name, "vector jump count", trapExpected ? 1 : 0, jumpCount);
        if (aluCount == 1 && regCount == 1) begin
            compareValue(name, "regWrite delay", 1, regCycle - aluCycle);
        end
        if (epcCount == 1 && jumpCount == 1) begin
            compareValue(name, "vector jump delay", 1, jumpCycle - epcCycle);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        overflow = 1'b0;
        opCode = ControlUnitPkg::OpAddiu;
        funct = '0;
        seed = 3;
        mismatchCount = 0;
        failureCount = 0;
        memReadRun = 0;
        vectorsReady = 1'b0;
        readVectors();
        vectorsReady = 1'b1;

        // Two reset cycles and the cycle where it drops
        @(posedge clk);
        @(negedge clk);
        verifyResetState();
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        verifyResetState();

        if (vectors.size() == 0) begin
            requireTrue(1'b0, "no test entries were read from the stimulus file");
        end else begin
            waitFirstFetch();
            foreach (vectors[i]) begin
                runInstruction(names[i], vectors[i]);
            end
        end
        finishRun();
    end

    initial begin
        int limitCycles;
        wait (vectorsReady);
        limitCycles = (vectors.size() + 2) * CyclesPerEntry;
        #(limitCycles * ClockPeriod);
        $display("Error: run did not finish within %0d cycles", limitCycles);
        failureCount++;
        finishRun();
    end

endmodule

`default_nettype wire

// ==== ControlUnit.f ====
rtl/ControlUnitPkg.sv
rtl/InstructionDecoder.sv
rtl/CycleSequencer.sv
rtl/ControlWordGen.sv
rtl/ControlUnit.sv
tests/ControlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ControlUnitTb
FLAGS ?= --assert --timing
FILELIST := ControlUnit.f
BIN := obj_dir/V$(TOP)
PASS_TEXT := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== tests/ControlUnit_stimulus.txt ====
# Columns: name opCode funct overflow aluOp regDst cause interval, all hex
# aluOp 0 add 1 sub 2 and; regDst 0 rt 1 rd; cause 0 none 1 overflow 2 illegal
add_basic 00 20 0 0 1 0 8
sub_basic 00 22 0 1 1 0 8
and_basic 00 24 0 2 1 0 8
addi_basic 08 00 0 0 0 0 8
addiu_basic 09 00 0 0 0 0 8
addi_field 08 3f 0 0 0 0 8
addiu_field 09 2a 0 0 0 0 8
add_overflow 00 20 1 0 0 1 9
sub_overflow 00 22 1 1 0 1 9
addi_overflow 08 11 1 0 0 1 9
and_overflow 00 24 1 2 1 0 8
addiu_overflow 09 05 1 0 0 0 8
add_after_trap 00 20 0 0 1 0 8
illegal_op_lw 23 00 0 0 0 2 8
illegal_op_sw 2b 00 0 0 0 2 8
illegal_op_j 02 00 0 0 0 2 8
illegal_op_beq 04 00 0 0 0 2 8
illegal_op_andi 0c 24 0 0 0 2 8
illegal_op_ori 0d 25 0 0 0 2 8
illegal_op_lui 0f 00 0 0 0 2 8
illegal_op_max 3f 3f 0 0 0 2 8
illegal_op_ovf 23 20 1 0 0 2 8
illegal_fn_addu 00 21 0 0 0 2 8
illegal_fn_subu 00 23 0 0 0 2 8
illegal_fn_or 00 25 0 0 0 2 8
illegal_fn_sll 00 00 0 0 0 2 8
illegal_fn_jr 00 08 0 0 0 2 8
illegal_fn_mult 00 18 0 0 0 2 8
illegal_fn_break 00 0d 0 0 0 2 8
illegal_fn_ovf 00 26 1 0 0 2 8
sub_after_illegal 00 22 0 1 1 0 8
and_after_illegal 00 24 0 2 1 0 8
addi_mixed 08 20 0 0 0 0 8
add_repeat_ovf 00 20 1 0 0 1 9
sub_repeat_ovf 00 22 1 1 0 1 9
addiu_final 09 3f 1 0 0 0 8
add_final 00 20 0 0 1 0 8
